//--- Makefile
# Verilator build and run of the event-status register testbench

VERILATOR ?= verilator
TOP       ?= evt_regs_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	-$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF '*** FAILED ***' $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -qF '*** PASSED ***' $(LOG); then echo "Simulation did not complete"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- all.f
hw/reg_access_pkg.sv
hw/reg_map_pkg.sv
hw/reg_bus_if.sv
hw/subreg_arb.sv
hw/subreg.sv
hw/hw_event_unit.sv
hw/host_port.sv
hw/reg_block.sv
hw/evt_regs_top.sv
verification/evt_regs_chk.sv
verification/evt_regs_tb.sv

//--- hw/evt_regs_top.sv
/*
 * Event-status register block top level
 * Host port, register block and hardware event unit
 */
`timescale 1ns/10ps

module evt_regs_top #(
  parameter int EVT_W = 4
) (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              req,
  input  logic                              write,
  input  logic [reg_map_pkg::ADDR_W-1:0]    addr,
  input  logic [reg_access_pkg::DATA_W-1:0] wdata,
  output logic                              rvalid,
  output logic [reg_access_pkg::DATA_W-1:0] rdata,
  output logic                              err,
  input  logic [EVT_W-1:0]                  evt,
  input  logic [reg_map_pkg::ERR_W-1:0]     err_in,
  input  logic [reg_map_pkg::MODE_W-1:0]    mode_clr,
  input  logic                              capture,
  output logic                              irq
);
  import reg_access_pkg::*;
  import reg_map_pkg::*;

  logic              count_de, snap_de, intr_de, mode_de, err_de, latch_de;
  logic [CNT_W-1:0]  count_d, count_q;
  logic [DATA_W-1:0] snap_d;
  logic [EVT_W-1:0]  intr_d, intr_q;
  logic [MODE_W-1:0] mode_d, mode_q;
  logic [ERR_W-1:0]  err_d, err_q, latch_d;

  reg_bus_if #(.ADDR_W(ADDR_W)) bus ();

  host_port host_port_i (
    .clk, .reset, .req, .write, .addr, .wdata,
    .rvalid, .rdata, .err, .bus(bus.host));

  reg_block #(.EVT_W(EVT_W)) reg_block_i (
    .clk, .reset, .bus(bus.dev),
    .count_de, .count_d, .snap_de, .snap_d, .intr_de, .intr_d,
    .mode_de, .mode_d, .err_de, .err_d, .latch_de, .latch_d,
    .count_q, .intr_q, .mode_q, .err_q, .irq);

  hw_event_unit #(.EVT_W(EVT_W)) hw_event_unit_i (
    .clk, .reset, .evt, .err_in, .mode_clr, .capture,
    .count_q, .intr_q, .mode_q, .err_q,
    .count_de, .count_d, .snap_de, .snap_d, .intr_de, .intr_d,
    .mode_de, .mode_d, .err_de, .err_d, .latch_de, .latch_d);

endmodule

//--- hw/host_port.sv
/*
 * Host port
 * Pipelines host requests onto the register bus and
 * returns read data, rvalid and err two cycles later
 */
`timescale 1ns/10ps

module host_port (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              req,
  input  logic                              write,
  input  logic [reg_map_pkg::ADDR_W-1:0]    addr,
  input  logic [reg_access_pkg::DATA_W-1:0] wdata,
  output logic                              rvalid,
  output logic [reg_access_pkg::DATA_W-1:0] rdata,
  output logic                              err,
  reg_bus_if.host                           bus
);

  // Request stage
  always_ff @(posedge clk) begin
    if (reset) begin
      bus.we <= 1'b0;
      bus.re <= 1'b0;
    end else begin
      bus.we <= req & write;
      bus.re <= req & ~write;
    end
  end

  always_ff @(posedge clk) begin
    bus.addr  <= addr;
    bus.wdata <= wdata;
  end

  // Response stage
  always_ff @(posedge clk) begin
    if (reset) begin
      rvalid <= 1'b0;
      err    <= 1'b0;
    end else begin
      rvalid <= bus.re;
      // Unmapped writes report err too
      err    <= (bus.we | bus.re) & bus.err;
    end
  end

  always_ff @(posedge clk) begin
    if (bus.re) begin
      rdata <= bus.rdata;
    end
  end

endmodule

//--- hw/hw_event_unit.sv
/*
 * Hardware event unit
 * Registers event, error, clear and capture inputs and
 * forms update strobes and data for the register slices
 */
`timescale 1ns/10ps

module hw_event_unit #(
  parameter int EVT_W = 4
) (
  input  logic                             clk,
  input  logic                             reset,
  input  logic [EVT_W-1:0]                 evt,
  input  logic [reg_map_pkg::ERR_W-1:0]    err_in,
  input  logic [reg_map_pkg::MODE_W-1:0]   mode_clr,
  input  logic                             capture,
  input  logic [reg_map_pkg::CNT_W-1:0]    count_q,
  input  logic [EVT_W-1:0]                 intr_q,
  input  logic [reg_map_pkg::MODE_W-1:0]   mode_q,
  input  logic [reg_map_pkg::ERR_W-1:0]    err_q,
  output logic                             count_de,
  output logic [reg_map_pkg::CNT_W-1:0]    count_d,
  output logic                             snap_de,
  output logic [reg_access_pkg::DATA_W-1:0] snap_d,
  output logic                             intr_de,
  output logic [EVT_W-1:0]                 intr_d,
  output logic                             mode_de,
  output logic [reg_map_pkg::MODE_W-1:0]   mode_d,
  output logic                             err_de,
  output logic [reg_map_pkg::ERR_W-1:0]    err_d,
  output logic                             latch_de,
  output logic [reg_map_pkg::ERR_W-1:0]    latch_d
);
  import reg_access_pkg::*;
  import reg_map_pkg::*;

  logic [EVT_W-1:0]  evt_r;
  logic [ERR_W-1:0]  err_r;
  logic [MODE_W-1:0] clr_r;
  logic              cap_r;
  logic [CNT_W-1:0]  evt_sum;

  // One input stage gives the single-cycle update latency
  always_ff @(posedge clk) begin
    if (reset) begin
      evt_r <= '0;
      err_r <= '0;
      clr_r <= '0;
      cap_r <= 1'b0;
    end else begin
      evt_r <= evt;
      err_r <= err_in;
      clr_r <= mode_clr;
      cap_r <= capture;
    end
  end

  // Number of events this cycle
  always_comb begin
    evt_sum = '0;
    for (int i = 0; i < EVT_W; i++) begin
      evt_sum = evt_sum + CNT_W'(evt_r[i]);
    end
  end

  // Counter wraps at CNT_W
  assign count_de = |evt_r;
  assign count_d  = count_q + evt_sum;

  assign snap_de = cap_r;
  assign snap_d  = DATA_W'(count_q);

  assign intr_de = |evt_r;
  assign intr_d  = intr_q | evt_r;

  assign mode_de = |clr_r;
  assign mode_d  = mode_q & ~clr_r;

  assign err_de = |err_r;
  assign err_d  = err_q | err_r;

  // Read-clear slice takes the new bits only
  assign latch_de = |err_r;
  assign latch_d  = err_r;

endmodule

//--- hw/reg_access_pkg.sv
/*
 * Software access modes of a register slice
 * Bus data width shared by slices and arbiters
 */
package reg_access_pkg;

  parameter int DATA_W = 32;

  // Software view of a slice
  typedef enum logic [2:0] {
    SW_RW  = 3'd0,
    SW_RO  = 3'd1,
    SW_W1S = 3'd2,
    SW_W1C = 3'd3,
    SW_W0C = 3'd4,
    SW_RC  = 3'd5
  } sw_access_e;

endpackage

//--- hw/reg_block.sv
/*
 * Register block with six slices
 * Address decode, read mux, read-clear pulse and irq
 */
`timescale 1ns/10ps

module reg_block #(
  parameter int EVT_W = 4
) (
  input  logic                              clk,
  input  logic                              reset,
  reg_bus_if.dev                            bus,
  input  logic                              count_de,
  input  logic [reg_map_pkg::CNT_W-1:0]     count_d,
  input  logic                              snap_de,
  input  logic [reg_access_pkg::DATA_W-1:0] snap_d,
  input  logic                              intr_de,
  input  logic [EVT_W-1:0]                  intr_d,
  input  logic                              mode_de,
  input  logic [reg_map_pkg::MODE_W-1:0]    mode_d,
  input  logic                              err_de,
  input  logic [reg_map_pkg::ERR_W-1:0]     err_d,
  input  logic                              latch_de,
  input  logic [reg_map_pkg::ERR_W-1:0]     latch_d,
  output logic [reg_map_pkg::CNT_W-1:0]     count_q,
  output logic [EVT_W-1:0]                  intr_q,
  output logic [reg_map_pkg::MODE_W-1:0]    mode_q,
  output logic [reg_map_pkg::ERR_W-1:0]     err_q,
  output logic                              irq
);
  import reg_access_pkg::*;
  import reg_map_pkg::*;

  logic              hit_snap, hit_count, hit_intr, hit_mode, hit_err, hit_latch;
  logic [DATA_W-1:0] snap_q;
  logic [ERR_W-1:0]  latch_q;

  // Exact byte address match, anything else is unmapped
  assign hit_snap  = (bus.addr == SNAPSHOT_OFS);
  assign hit_count = (bus.addr == EVT_COUNT_OFS);
  assign hit_intr  = (bus.addr == INTR_STATE_OFS);
  assign hit_mode  = (bus.addr == MODE_OFS);
  assign hit_err   = (bus.addr == ERR_FLAGS_OFS);
  assign hit_latch = (bus.addr == ERR_LATCH_OFS);

  assign bus.err = ~(hit_snap | hit_count | hit_intr | hit_mode | hit_err | hit_latch);

  subreg #(.value_t(logic [DATA_W-1:0]), .SwAccess(SW_RW),
           .RESET_VAL(SNAPSHOT_RESET[DATA_W-1:0])) snapshot_i (
    .clk, .reset, .we(bus.we & hit_snap), .wd(bus.wdata),
    .de(snap_de), .d(snap_d), .q(snap_q));

  // Writes to the counter address are accepted and ignored
  subreg #(.value_t(logic [CNT_W-1:0]), .SwAccess(SW_RO),
           .RESET_VAL(EVT_COUNT_RESET[CNT_W-1:0])) evt_count_i (
    .clk, .reset, .we(bus.we & hit_count), .wd(bus.wdata[CNT_W-1:0]),
    .de(count_de), .d(count_d), .q(count_q));

  subreg #(.value_t(logic [EVT_W-1:0]), .SwAccess(SW_W1C),
           .RESET_VAL(INTR_STATE_RESET[EVT_W-1:0])) intr_state_i (
    .clk, .reset, .we(bus.we & hit_intr), .wd(bus.wdata[EVT_W-1:0]),
    .de(intr_de), .d(intr_d), .q(intr_q));

  subreg #(.value_t(logic [MODE_W-1:0]), .SwAccess(SW_W1S),
           .RESET_VAL(MODE_RESET[MODE_W-1:0])) mode_i (
    .clk, .reset, .we(bus.we & hit_mode), .wd(bus.wdata[MODE_W-1:0]),
    .de(mode_de), .d(mode_d), .q(mode_q));

  subreg #(.value_t(logic [ERR_W-1:0]), .SwAccess(SW_W0C),
           .RESET_VAL(ERR_FLAGS_RESET[ERR_W-1:0])) err_flags_i (
    .clk, .reset, .we(bus.we & hit_err), .wd(bus.wdata[ERR_W-1:0]),
    .de(err_de), .d(err_d), .q(err_q));

  // A read of err_latch is the clear pulse
  subreg #(.value_t(logic [ERR_W-1:0]), .SwAccess(SW_RC),
           .RESET_VAL(ERR_LATCH_RESET[ERR_W-1:0])) err_latch_i (
    .clk, .reset, .we(bus.re & hit_latch), .wd(bus.wdata[ERR_W-1:0]),
    .de(latch_de), .d(latch_d), .q(latch_q));

  // Read mux, unread bits return zero
  always_comb begin
    case (bus.addr)
      SNAPSHOT_OFS:   bus.rdata = snap_q;
      EVT_COUNT_OFS:  bus.rdata = DATA_W'(count_q);
      INTR_STATE_OFS: bus.rdata = DATA_W'(intr_q);
      MODE_OFS:       bus.rdata = DATA_W'(mode_q);
      ERR_FLAGS_OFS:  bus.rdata = DATA_W'(err_q);
      ERR_LATCH_OFS:  bus.rdata = DATA_W'(latch_q);
      default:        bus.rdata = '0;
    endcase
  end

  // Low mode bits enable each interrupt source
  always_ff @(posedge clk) begin
    if (reset) begin
      irq <= 1'b0;
    end else begin
      irq <= |(intr_q & mode_q[EVT_W-1:0]);
    end
  end

endmodule

//--- hw/reg_bus_if.sv
/*
 * Register bus between host port and register block
 * Single-cycle we/re strobes, combinational rdata and err
 */
`timescale 1ns/10ps

interface reg_bus_if #(
  parameter int ADDR_W = reg_map_pkg::ADDR_W
);
  import reg_access_pkg::*;

  logic              we;
  logic              re;
  logic [ADDR_W-1:0] addr;
  logic [DATA_W-1:0] wdata;
  logic [DATA_W-1:0] rdata;
  logic              err;

  modport host (output we, re, addr, wdata, input rdata, err);

  modport dev (input we, re, addr, wdata, output rdata, err);

endinterface

//--- hw/reg_map_pkg.sv
/*
 * Register map of the event-status block
 * Byte offsets, field widths and reset values
 */
package reg_map_pkg;

  parameter int ADDR_W = 5;

  // Byte offsets
  parameter logic [ADDR_W-1:0] SNAPSHOT_OFS   = 5'h00;
  parameter logic [ADDR_W-1:0] EVT_COUNT_OFS  = 5'h04;
  parameter logic [ADDR_W-1:0] INTR_STATE_OFS = 5'h08;
  parameter logic [ADDR_W-1:0] MODE_OFS       = 5'h0C;
  parameter logic [ADDR_W-1:0] ERR_FLAGS_OFS  = 5'h10;
  parameter logic [ADDR_W-1:0] ERR_LATCH_OFS  = 5'h14;

  // Field widths
  parameter int CNT_W  = 16;
  parameter int ERR_W  = 8;
  parameter int MODE_W = 8;

  // Reset values, truncated to the field width at each slice
  parameter logic [31:0] SNAPSHOT_RESET   = 32'h0000_0000;
  parameter logic [31:0] EVT_COUNT_RESET  = 32'h0000_0000;
  parameter logic [31:0] INTR_STATE_RESET = 32'h0000_0000;
  parameter logic [31:0] MODE_RESET       = 32'h0000_000F;
  parameter logic [31:0] ERR_FLAGS_RESET  = 32'h0000_0000;
  parameter logic [31:0] ERR_LATCH_RESET  = 32'h0000_0000;

endpackage

//--- hw/subreg.sv
/*
 * One register slice
 * Storage flop plus its write arbiter, payload set by value_t
 */
`timescale 1ns/10ps

module subreg #(
  parameter type                        value_t   = logic [31:0],
  parameter reg_access_pkg::sw_access_e SwAccess  = reg_access_pkg::SW_RW,
  parameter value_t                     RESET_VAL = '0
) (
  input  logic   clk,
  input  logic   reset,
  input  logic   we,
  input  value_t wd,
  input  logic   de,
  input  value_t d,
  output value_t q
);

  localparam int DW = $bits(value_t);

  logic          wr_en;
  logic [DW-1:0] wr_data;

  subreg_arb #(
    .DW       (DW),
    .SwAccess (SwAccess)
  ) arb_i (
    .we      (we),
    .wd      (wd),
    .de      (de),
    .d       (d),
    .q       (q),
    .wr_en   (wr_en),
    .wr_data (wr_data)
  );

  always_ff @(posedge clk) begin
    if (reset) begin
      q <= RESET_VAL;
    end else if (wr_en) begin
      q <= wr_data;
    end
  end

endmodule

//--- hw/subreg_arb.sv
/*
 * Write arbitration of one register slice
 * Merges software and hardware updates per access mode
 */
`timescale 1ns/10ps

module subreg_arb #(
  parameter int                         DW       = 32,
  parameter reg_access_pkg::sw_access_e SwAccess = reg_access_pkg::SW_RW
) (
  // Software side, for RC the read pulse arrives on we
  input  logic          we,
  input  logic [DW-1:0] wd,
  // Hardware side
  input  logic          de,
  input  logic [DW-1:0] d,
  // Current register value
  input  logic [DW-1:0] q,
  output logic          wr_en,
  output logic [DW-1:0] wr_data
);
  import reg_access_pkg::*;

  if (SwAccess == SW_RW) begin : gen_rw
    assign wr_en   = we | de;
    // Software data has priority
    assign wr_data = we ? wd : d;
  end else if (SwAccess == SW_RO) begin : gen_ro
    assign wr_en   = de;
    assign wr_data = d;
  end else if (SwAccess == SW_W1S) begin : gen_w1s
    // Hardware clears, software sets and wins on a shared bit
    assign wr_en   = we | de;
    assign wr_data = (de ? d : q) | (we ? wd : '0);
  end else if (SwAccess == SW_W1C) begin : gen_w1c
    // Hardware sets, software clears and wins on a shared bit
    assign wr_en   = we | de;
    assign wr_data = (de ? d : q) & (we ? ~wd : '1);
  end else if (SwAccess == SW_W0C) begin : gen_w0c
    assign wr_en   = we | de;
    assign wr_data = (de ? d : q) & (we ? wd : '1);
  end else begin : gen_rc
    // Hardware d holds only the bits being set in this cycle,
    // so they survive a read that clears the old value
    assign wr_en   = we | de;
    assign wr_data = (we ? '0 : q) | (de ? d : '0);
  end

endmodule

//--- verification/evt_regs_chk.sv
/*
 * Concurrent assertions bound to the top level
 * rvalid timing against read requests, irq against intr_state
 */
`timescale 1ns/10ps

module evt_regs_chk #(
  parameter int EVT_W = 4
) (
  input logic             clk,
  input logic             reset,
  input logic             req,
  input logic             write,
  input logic             rvalid,
  input logic             irq,
  input logic [EVT_W-1:0] intr_q
);

  logic rd;

  assign rd = req & ~write;

  // Response two cycles after each read request
  a_rvalid_after_read: assert property (@(posedge clk) disable iff (reset)
    $past(rd, 2) |-> rvalid)
    else $error("rvalid missing two cycles after a read request");

  a_rvalid_has_read: assert property (@(posedge clk) disable iff (reset)
    rvalid |-> $past(rd, 2))
    else $error("rvalid without a read request two cycles before");

  // One cycle per response, longer only for back-to-back reads
  a_rvalid_width: assert property (@(posedge clk) disable iff (reset)
    rvalid && !$past(rd) |=> !rvalid)
    else $error("rvalid held longer than one cycle");

  a_irq_low: assert property (@(posedge clk) disable iff (reset)
    intr_q == '0 |=> !irq)
    else $error("irq high while intr_state is zero");

endmodule

bind evt_regs_top evt_regs_chk #(.EVT_W(EVT_W)) evt_regs_chk_i (
  .clk(clk), .reset(reset), .req(req), .write(write),
  .rvalid(rvalid), .irq(irq), .intr_q(intr_q));

//--- verification/evt_regs_tb.sv
/*
 * Testbench for the event-status register top level
 * Clock, reset, directed and random stimulus, reference model,
 * compare process and closing report
 */
`timescale 1ns/10ps

module evt_regs_tb;
  import reg_access_pkg::*;
  import reg_map_pkg::*;

  localparam int EVT_W = 4;

  // Shadow copy of the six registers
  typedef struct packed {
    logic [DATA_W-1:0] snapshot;
    logic [CNT_W-1:0]  count;
    logic [EVT_W-1:0]  intr;
    logic [MODE_W-1:0] mode;
    logic [ERR_W-1:0]  err;
    logic [ERR_W-1:0]  latch;
  } shadow_t;

  // Inputs seen at one rising edge
  typedef struct packed {
    logic              req;
    logic              write;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [EVT_W-1:0]  evt;
    logic [ERR_W-1:0]  err_in;
    logic [MODE_W-1:0] mode_clr;
    logic              capture;
  } stim_t;

  logic              clk, reset, req, write, capture;
  logic              rvalid, err, irq;
  logic [ADDR_W-1:0] addr;
  logic [DATA_W-1:0] wdata, rdata;
  logic [EVT_W-1:0]  evt;
  logic [ERR_W-1:0]  err_in;
  logic [MODE_W-1:0] mode_clr;

  shadow_t           shadow;
  stim_t             pend;
  logic              exp_err, exp_irq, model_live;
  logic [DATA_W-1:0] exp_q[$];
  int                outstanding, n_checks, n_errors, n_tests, test_start_errors;

  evt_regs_top #(.EVT_W(EVT_W)) evt_regs_top_i (
    .clk, .reset, .req, .write, .addr, .wdata, .rvalid, .rdata, .err,
    .evt, .err_in, .mode_clr, .capture, .irq);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic shadow_t reset_shadow();
    shadow_t s;
    s      = '0;
    s.mode = 8'h0F;
    return s;
  endfunction

  function automatic logic is_mapped(logic [ADDR_W-1:0] a);
    return a inside {SNAPSHOT_OFS, EVT_COUNT_OFS, INTR_STATE_OFS,
                     MODE_OFS, ERR_FLAGS_OFS, ERR_LATCH_OFS};
  endfunction

  function automatic logic [DATA_W-1:0] read_value(shadow_t s, logic [ADDR_W-1:0] a);
    logic [DATA_W-1:0] r;
    case (a)
      SNAPSHOT_OFS:   r = s.snapshot;
      EVT_COUNT_OFS:  r = DATA_W'(s.count);
      INTR_STATE_OFS: r = DATA_W'(s.intr);
      MODE_OFS:       r = DATA_W'(s.mode);
      ERR_FLAGS_OFS:  r = DATA_W'(s.err);
      ERR_LATCH_OFS:  r = DATA_W'(s.latch);
      default:        r = '0;
    endcase
    return r;
  endfunction

  // Register state after one edge, hardware first, then software on top
  function automatic shadow_t next_state(shadow_t s, stim_t p);
    shadow_t n;
    n = s;
    for (int i = 0; i < EVT_W; i++) begin
      n.count = n.count + CNT_W'(p.evt[i]);
    end
    if (p.capture) begin
      n.snapshot = DATA_W'(s.count);
    end
    n.intr  = s.intr | p.evt;
    n.mode  = s.mode & ~p.mode_clr;
    n.err   = s.err | p.err_in;
    n.latch = s.latch | p.err_in;
    if (p.req && p.write) begin
      case (p.addr)
        SNAPSHOT_OFS:   n.snapshot = p.wdata;
        INTR_STATE_OFS: n.intr = n.intr & ~p.wdata[EVT_W-1:0];
        MODE_OFS:       n.mode = n.mode | p.wdata[MODE_W-1:0];
        ERR_FLAGS_OFS:  n.err = n.err & p.wdata[ERR_W-1:0];
        default:        ;
      endcase
    end
    // Read clear keeps only bits set in the same cycle
    if (p.req && !p.write && p.addr == ERR_LATCH_OFS) begin
      n.latch = p.err_in;
    end
    return n;
  endfunction

  function automatic logic [ADDR_W-1:0] pick_addr(int idx);
    if (idx < 6) begin
      return ADDR_W'(idx * 4);
    end
    return (idx == 6) ? 5'h18 : 5'h02;
  endfunction

  // Reference model, one step per rising edge
  always @(posedge clk) begin
    if (reset) begin
      shadow  = reset_shadow();
      pend    = '0;
      exp_err = 1'b0;
      exp_irq = 1'b0;
    end else begin
      model_live = 1'b1;
      if (pend.req && !pend.write) begin
        exp_q.push_back(read_value(shadow, pend.addr));
      end
      exp_err = pend.req & ~is_mapped(pend.addr);
      exp_irq = |(shadow.intr & shadow.mode[EVT_W-1:0]);
      shadow  = next_state(shadow, pend);
      pend    = {req, write, addr, wdata, evt, err_in, mode_clr, capture};
    end
  end

  task automatic check_data(input string name, input logic [DATA_W-1:0] got,
                            input logic [DATA_W-1:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("ERROR t=%0t %s: got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("ERROR t=%0t %s: got %b expected %b", $time, name, got, exp);
    end
  endtask

  // Outputs are all registered, so the falling edge sees them settled
  always @(negedge clk) begin
    if (model_live) begin
      check_flag("err", err, exp_err);
      check_flag("irq", irq, exp_irq);
      if (rvalid) begin
        outstanding--;
        if (exp_q.size() == 0) begin
          n_errors++;
          $display("rvalid arrived at %0t with no read outstanding", $time);
        end else begin
          check_data("rdata", rdata, exp_q.pop_front());
        end
      end
    end
  end

  task automatic drive_cycle(input logic rq, input logic wr, input logic [ADDR_W-1:0] a,
                             input logic [DATA_W-1:0] wd, input logic [EVT_W-1:0] ev,
                             input logic [ERR_W-1:0] ei, input logic [MODE_W-1:0] mc,
                             input logic cap);
    @(negedge clk);
    req      = rq;
    write    = wr;
    addr     = a;
    wdata    = wd;
    evt      = ev;
    err_in   = ei;
    mode_clr = mc;
    capture  = cap;
    if (rq && !wr) begin
      outstanding++;
    end
  endtask

  task automatic read_reg(input logic [ADDR_W-1:0] a);
    drive_cycle(1'b1, 1'b0, a, '0, '0, '0, '0, 1'b0);
  endtask

  task automatic write_reg(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
    drive_cycle(1'b1, 1'b1, a, d, '0, '0, '0, 1'b0);
  endtask

  task automatic hw_pulse(input logic [EVT_W-1:0] ev, input logic [ERR_W-1:0] ei,
                          input logic [MODE_W-1:0] mc, input logic cap);
    drive_cycle(1'b0, 1'b0, '0, '0, ev, ei, mc, cap);
  endtask

  task automatic idle(input int n);
    for (int i = 0; i < n; i++) begin
      drive_cycle(1'b0, 1'b0, '0, '0, '0, '0, '0, 1'b0);
    end
  endtask

  // Wait for every read to come back, bounded
  task automatic wait_idle();
    int cycles;
    idle(1);
    cycles = 0;
    while (outstanding != 0 && cycles < 50) begin
      @(negedge clk);
      cycles++;
    end
    if (outstanding != 0) begin
      n_errors++;
      $display("Timeout with %0d reads still waiting for rvalid", outstanding);
    end
    idle(3);
  endtask

  task automatic end_test(input string name);
    wait_idle();
    n_tests++;
    $display("test %0d %s: %0d errors", n_tests, name, n_errors - test_start_errors);
    test_start_errors = n_errors;
  endtask

  initial begin
    int idx;
    void'($urandom(32'he0b5_238f));
    reset    = 1'b1;
    req      = 1'b0;
    write    = 1'b0;
    addr     = '0;
    wdata    = '0;
    evt      = '0;
    err_in   = '0;
    mode_clr = '0;
    capture  = 1'b0;
    model_live        = 1'b0;
    outstanding       = 0;
    n_checks          = 0;
    n_errors          = 0;
    n_tests           = 0;
    test_start_errors = 0;
    repeat (10) @(negedge clk);
    reset = 1'b0;

    for (int i = 0; i < 6; i++) begin
      read_reg(pick_addr(i));
    end
    check_flag("irq", irq, 1'b0);
    end_test("reset values");

    write_reg(SNAPSHOT_OFS, 32'hA5A5_1234);
    read_reg(SNAPSHOT_OFS);
    hw_pulse(4'b1011, '0, '0, 1'b0);
    hw_pulse('0, '0, '0, 1'b1);
    read_reg(SNAPSHOT_OFS);
    // Write and capture on the same edge
    drive_cycle(1'b1, 1'b1, SNAPSHOT_OFS, 32'h0BAD_F00D, '0, '0, '0, 1'b1);
    read_reg(SNAPSHOT_OFS);
    end_test("snapshot write and capture");

    for (int i = 0; i < 20; i++) begin
      hw_pulse(EVT_W'($urandom), '0, '0, 1'b0);
    end
    read_reg(EVT_COUNT_OFS);
    read_reg(INTR_STATE_OFS);
    drive_cycle(1'b1, 1'b1, INTR_STATE_OFS, 32'h5, 4'b0110, '0, '0, 1'b0);
    read_reg(INTR_STATE_OFS);
    read_reg(EVT_COUNT_OFS);
    end_test("event count and intr_state");

    write_reg(MODE_OFS, 32'hF0);
    hw_pulse('0, '0, 8'h03, 1'b0);
    read_reg(MODE_OFS);
    drive_cycle(1'b1, 1'b1, MODE_OFS, 32'h01, '0, '0, 8'h81, 1'b0);
    read_reg(MODE_OFS);
    hw_pulse(4'b0101, '0, 8'h0F, 1'b0);
    idle(3);
    check_flag("irq", irq, 1'b0);
    write_reg(MODE_OFS, 32'h05);
    read_reg(MODE_OFS);
    end_test("mode set, clear and irq");

    hw_pulse('0, 8'h81, '0, 1'b0);
    read_reg(ERR_FLAGS_OFS);
    write_reg(ERR_FLAGS_OFS, 32'h80);
    read_reg(ERR_FLAGS_OFS);
    hw_pulse('0, 8'h12, '0, 1'b0);
    drive_cycle(1'b1, 1'b0, ERR_LATCH_OFS, '0, '0, 8'h04, '0, 1'b0);
    read_reg(ERR_LATCH_OFS);
    end_test("err_flags and err_latch");

    for (int i = 0; i < 40; i++) begin
      idx = $urandom_range(7, 0);
      drive_cycle(1'($urandom), 1'($urandom), pick_addr(idx), $urandom,
                  ($urandom_range(3, 0) == 0) ? EVT_W'($urandom) : '0,
                  ($urandom_range(3, 0) == 0) ? ERR_W'($urandom) : '0,
                  ($urandom_range(3, 0) == 0) ? MODE_W'($urandom) : '0,
                  ($urandom_range(7, 0) == 0));
    end
    end_test("mixed back-to-back requests");

    $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule
